//--- mips_pkg.sv
package mips_pkg;

    //--------------------------------------------------------------------------
    // widths
    //--------------------------------------------------------------------------
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    //--------------------------------------------------------------------------
    // instruction encodings
    //--------------------------------------------------------------------------
    // primary opcode, bits 31:26
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000,
        OP_ADDI    = 6'b001000,
        OP_ADDIU   = 6'b001001,
        OP_SLTI    = 6'b001010,
        OP_SLTIU   = 6'b001011,
        OP_ANDI    = 6'b001100,
        OP_ORI     = 6'b001101,
        OP_XORI    = 6'b001110,
        OP_LUI     = 6'b001111
    } opcode_e;

    // function field of SPECIAL, bits 5:0
    typedef enum logic [5:0] {
        FN_SLL  = 6'b000000,
        FN_SRL  = 6'b000010,
        FN_SRA  = 6'b000011,
        FN_SLLV = 6'b000100,
        FN_SRLV = 6'b000110,
        FN_SRAV = 6'b000111,
        FN_ADD  = 6'b100000,
        FN_ADDU = 6'b100001,
        FN_SUB  = 6'b100010,
        FN_SUBU = 6'b100011,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_XOR  = 6'b100110,
        FN_NOR  = 6'b100111,
        FN_SLT  = 6'b101010,
        FN_SLTU = 6'b101011
    } funct_e;

    // alu operation, selects the result on its own
    typedef enum logic [3:0] {
        ALU_AND  = 4'd0,
        ALU_OR   = 4'd1,
        ALU_XOR  = 4'd2,
        ALU_NOR  = 4'd3,
        ALU_SLL  = 4'd4,
        ALU_SRL  = 4'd5,
        ALU_SRA  = 4'd6,
        ALU_ADD  = 4'd7,
        ALU_ADDU = 4'd8,
        ALU_SUB  = 4'd9,
        ALU_SUBU = 4'd10,
        ALU_SLT  = 4'd11,
        ALU_SLTU = 4'd12
    } alu_op_e;

    //--------------------------------------------------------------------------
    // stage records
    //--------------------------------------------------------------------------
    // decode -> execute
    typedef struct packed {
        logic                  valid;
        logic                  reg_write;
        logic [REG_ADDR_W-1:0] waddr;
        alu_op_e               alu_op;
        logic                  rs_read;
        logic [REG_ADDR_W-1:0] rs_addr;
        logic                  rt_read;
        logic [REG_ADDR_W-1:0] rt_addr;
        logic                  use_imm;
        logic [XLEN-1:0]       imm;
        logic                  excp_ri;
    } dec_t;

    // execute -> writeback
    typedef struct packed {
        logic                  valid;
        logic                  reg_write;
        logic [REG_ADDR_W-1:0] waddr;
        logic [XLEN-1:0]       wdata;
        logic                  excp_ri;
        logic                  excp_ov;
    } exe_t;

    // report at the core output
    typedef struct packed {
        logic                  valid;
        logic                  reg_write;
        logic [REG_ADDR_W-1:0] waddr;
        logic [XLEN-1:0]       wdata;
        logic                  excp_ri;
        logic                  excp_ov;
    } wb_t;

endpackage

//--- inst_decode.sv
module inst_decode (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    input  logic                     inst_valid_i,
    input  logic [mips_pkg::XLEN-1:0] inst_i,
    output mips_pkg::dec_t           dec_o
);

    // immediate forms the decoder can build
    typedef enum logic [1:0] {
        IMM_SHAMT,
        IMM_ZERO,
        IMM_UPPER,
        IMM_SIGN
    } imm_kind_e;

    //--------------------------------------------------------------------------
    // instruction fields
    //--------------------------------------------------------------------------
    mips_pkg::opcode_e                 opcode;
    mips_pkg::funct_e                  funct;
    logic [mips_pkg::REG_ADDR_W-1:0]   rs;
    logic [mips_pkg::REG_ADDR_W-1:0]   rt;
    logic [mips_pkg::REG_ADDR_W-1:0]   rd;
    logic [mips_pkg::REG_ADDR_W-1:0]   shamt;
    logic [15:0]                       imm16;

    assign opcode = mips_pkg::opcode_e'(inst_i[31:26]);
    assign rs     = inst_i[25:21];
    assign rt     = inst_i[20:16];
    assign rd     = inst_i[15:11];
    assign shamt  = inst_i[10:6];
    assign funct  = mips_pkg::funct_e'(inst_i[5:0]);
    assign imm16  = inst_i[15:0];

    logic                 excp_ri;
    logic                 reg_write;
    logic                 use_rd;
    logic                 rs_read;
    logic                 rt_read;
    logic                 use_imm;
    imm_kind_e            imm_kind;
    mips_pkg::alu_op_e    alu_op;
    logic [mips_pkg::XLEN-1:0] imm_ext;
    mips_pkg::dec_t       dec_d;
    mips_pkg::dec_t       dec_q;

    //--------------------------------------------------------------------------
    // classification
    //--------------------------------------------------------------------------
    always_comb begin
        // unmatched words fall through as reserved
        excp_ri   = 1'b1;
        reg_write = 1'b0;
        use_rd    = 1'b0;
        rs_read   = 1'b0;
        rt_read   = 1'b0;
        use_imm   = 1'b1;
        imm_kind  = IMM_SIGN;
        alu_op    = mips_pkg::ALU_AND;
        case (opcode)
            mips_pkg::OP_SPECIAL: begin
                case (funct)
                    mips_pkg::FN_SLL, mips_pkg::FN_SRL, mips_pkg::FN_SRA: begin
                        // shift by shamt, rs must be zero
                        if (rs == '0) begin
                            excp_ri  = 1'b0;
                            rt_read  = 1'b1;
                            use_imm  = 1'b0;
                            imm_kind = IMM_SHAMT;
                        end
                    end
                    mips_pkg::FN_SLLV, mips_pkg::FN_SRLV, mips_pkg::FN_SRAV,
                    mips_pkg::FN_ADD, mips_pkg::FN_ADDU, mips_pkg::FN_SUB,
                    mips_pkg::FN_SUBU, mips_pkg::FN_AND, mips_pkg::FN_OR,
                    mips_pkg::FN_XOR, mips_pkg::FN_NOR, mips_pkg::FN_SLT,
                    mips_pkg::FN_SLTU: begin
                        if (shamt == '0) begin
                            excp_ri = 1'b0;
                            rs_read = 1'b1;
                            rt_read = 1'b1;
                            use_imm = 1'b0;
                        end
                    end
                    default: ;
                endcase
                use_rd    = !excp_ri;
                reg_write = !excp_ri;
                if (!excp_ri) begin
                    case (funct)
                        mips_pkg::FN_SLL, mips_pkg::FN_SLLV: alu_op = mips_pkg::ALU_SLL;
                        mips_pkg::FN_SRL, mips_pkg::FN_SRLV: alu_op = mips_pkg::ALU_SRL;
                        mips_pkg::FN_SRA, mips_pkg::FN_SRAV: alu_op = mips_pkg::ALU_SRA;
                        mips_pkg::FN_ADD:  alu_op = mips_pkg::ALU_ADD;
                        mips_pkg::FN_ADDU: alu_op = mips_pkg::ALU_ADDU;
                        mips_pkg::FN_SUB:  alu_op = mips_pkg::ALU_SUB;
                        mips_pkg::FN_SUBU: alu_op = mips_pkg::ALU_SUBU;
                        mips_pkg::FN_OR:   alu_op = mips_pkg::ALU_OR;
                        mips_pkg::FN_XOR:  alu_op = mips_pkg::ALU_XOR;
                        mips_pkg::FN_NOR:  alu_op = mips_pkg::ALU_NOR;
                        mips_pkg::FN_SLT:  alu_op = mips_pkg::ALU_SLT;
                        mips_pkg::FN_SLTU: alu_op = mips_pkg::ALU_SLTU;
                        default:           alu_op = mips_pkg::ALU_AND;
                    endcase
                end
            end
            mips_pkg::OP_ADDI, mips_pkg::OP_ADDIU, mips_pkg::OP_SLTI,
            mips_pkg::OP_SLTIU, mips_pkg::OP_ANDI, mips_pkg::OP_ORI,
            mips_pkg::OP_XORI, mips_pkg::OP_LUI: begin
                // lui also needs rs clear
                if (opcode != mips_pkg::OP_LUI || rs == '0) begin
                    excp_ri   = 1'b0;
                    reg_write = 1'b1;
                    rs_read   = 1'b1;
                end
                case (opcode)
                    mips_pkg::OP_ADDI:  alu_op = mips_pkg::ALU_ADD;
                    mips_pkg::OP_ADDIU: alu_op = mips_pkg::ALU_ADDU;
                    mips_pkg::OP_SLTI:  alu_op = mips_pkg::ALU_SLT;
                    mips_pkg::OP_SLTIU: alu_op = mips_pkg::ALU_SLTU;
                    mips_pkg::OP_ANDI:  alu_op = mips_pkg::ALU_AND;
                    mips_pkg::OP_XORI:  alu_op = mips_pkg::ALU_XOR;
                    default:            alu_op = mips_pkg::ALU_OR;
                endcase
                if (opcode == mips_pkg::OP_LUI) begin
                    imm_kind = IMM_UPPER;
                end else if (opcode == mips_pkg::OP_ANDI || opcode == mips_pkg::OP_ORI ||
                             opcode == mips_pkg::OP_XORI) begin
                    imm_kind = IMM_ZERO;
                end
            end
            default: ;
        endcase
    end

    always_comb begin
        case (imm_kind)
            IMM_SHAMT: imm_ext = {{(mips_pkg::XLEN-mips_pkg::REG_ADDR_W){1'b0}}, shamt};
            IMM_ZERO:  imm_ext = {{(mips_pkg::XLEN-16){1'b0}}, imm16};
            IMM_UPPER: imm_ext = {imm16, {(mips_pkg::XLEN-16){1'b0}}};
            default:   imm_ext = {{(mips_pkg::XLEN-16){imm16[15]}}, imm16};
        endcase
    end

    // reserved words carry a zero immediate so they compute zero
    always_comb begin
        dec_d.valid     = 1'b1;
        dec_d.reg_write = reg_write;
        dec_d.waddr     = use_rd ? rd : rt;
        dec_d.alu_op    = alu_op;
        dec_d.rs_read   = rs_read;
        dec_d.rs_addr   = rs;
        dec_d.rt_read   = rt_read;
        dec_d.rt_addr   = rt;
        dec_d.use_imm   = use_imm;
        dec_d.imm       = excp_ri ? '0 : imm_ext;
        dec_d.excp_ri   = excp_ri;
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            dec_q <= '0;
        end else if (inst_valid_i) begin
            dec_q <= dec_d;
        end else begin
            dec_q.valid <= 1'b0;
        end
    end

    assign dec_o = dec_q;

    a_ri_no_write: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        dec_q.valid |-> !(dec_q.excp_ri && dec_q.reg_write));

endmodule

//--- alu_execute.sv
module alu_execute (
    input  logic                              clk_i,
    input  logic                              arst_n_i,
    input  mips_pkg::dec_t                    dec_i,
    output logic [mips_pkg::REG_ADDR_W-1:0]   rd_addr_a_o,
    output logic [mips_pkg::REG_ADDR_W-1:0]   rd_addr_b_o,
    input  logic [mips_pkg::XLEN-1:0]         rd_data_a_i,
    input  logic [mips_pkg::XLEN-1:0]         rd_data_b_i,
    output mips_pkg::exe_t                    exe_o
);

    mips_pkg::exe_t               exe_q;
    mips_pkg::exe_t               exe_d;
    logic                         exe_commit;
    logic                         fwd_a;
    logic                         fwd_b;
    logic [mips_pkg::XLEN-1:0]    rs_val;
    logic [mips_pkg::XLEN-1:0]    rt_val;
    logic [mips_pkg::XLEN-1:0]    src_a;
    logic [mips_pkg::XLEN-1:0]    src_b;
    logic [mips_pkg::XLEN-1:0]    sum;
    logic [mips_pkg::XLEN-1:0]    diff;
    logic [mips_pkg::REG_ADDR_W-1:0] sh_amt;
    logic [mips_pkg::XLEN-1:0]    result;
    logic                         ovf;

    assign rd_addr_a_o = dec_i.rs_addr;
    assign rd_addr_b_o = dec_i.rt_addr;

    //--------------------------------------------------------------------------
    // operand forwarding
    //--------------------------------------------------------------------------
    // result in flight that will land in the register file
    assign exe_commit = exe_q.valid && exe_q.reg_write && !exe_q.excp_ri && !exe_q.excp_ov;

    assign fwd_a = exe_commit && dec_i.rs_read && (dec_i.rs_addr != '0) &&
                   (dec_i.rs_addr == exe_q.waddr);
    assign fwd_b = exe_commit && dec_i.rt_read && (dec_i.rt_addr != '0) &&
                   (dec_i.rt_addr == exe_q.waddr);

    assign rs_val = fwd_a ? exe_q.wdata : rd_data_a_i;
    assign rt_val = fwd_b ? exe_q.wdata : rd_data_b_i;

    // fixed shifts take shamt from the immediate in place of rs
    assign src_a = dec_i.rs_read ? rs_val : dec_i.imm;
    assign src_b = dec_i.use_imm ? dec_i.imm : rt_val;

    //--------------------------------------------------------------------------
    // alu
    //--------------------------------------------------------------------------
    assign sum    = src_a + src_b;
    assign diff   = src_a - src_b;
    assign sh_amt = src_a[mips_pkg::REG_ADDR_W-1:0];

    always_comb begin
        case (dec_i.alu_op)
            mips_pkg::ALU_AND:  result = src_a & src_b;
            mips_pkg::ALU_OR:   result = src_a | src_b;
            mips_pkg::ALU_XOR:  result = src_a ^ src_b;
            mips_pkg::ALU_NOR:  result = ~(src_a | src_b);
            mips_pkg::ALU_SLL:  result = src_b << sh_amt;
            mips_pkg::ALU_SRL:  result = src_b >> sh_amt;
            mips_pkg::ALU_SRA:  result = $signed(src_b) >>> sh_amt;
            mips_pkg::ALU_ADD,
            mips_pkg::ALU_ADDU: result = sum;
            mips_pkg::ALU_SUB,
            mips_pkg::ALU_SUBU: result = diff;
            mips_pkg::ALU_SLT:  result = {{(mips_pkg::XLEN-1){1'b0}},
                                          $signed(src_a) < $signed(src_b)};
            mips_pkg::ALU_SLTU: result = {{(mips_pkg::XLEN-1){1'b0}}, src_a < src_b};
            default:            result = '0;
        endcase
    end

    // signed overflow, only the trapping add and sub
    always_comb begin
        ovf = 1'b0;
        if (dec_i.alu_op == mips_pkg::ALU_ADD) begin
            ovf = (src_a[mips_pkg::XLEN-1] == src_b[mips_pkg::XLEN-1]) &&
                  (sum[mips_pkg::XLEN-1] != src_a[mips_pkg::XLEN-1]);
        end else if (dec_i.alu_op == mips_pkg::ALU_SUB) begin
            ovf = (src_a[mips_pkg::XLEN-1] != src_b[mips_pkg::XLEN-1]) &&
                  (diff[mips_pkg::XLEN-1] != src_a[mips_pkg::XLEN-1]);
        end
    end

    always_comb begin
        exe_d.valid     = dec_i.valid;
        exe_d.reg_write = dec_i.reg_write;
        exe_d.waddr     = dec_i.waddr;
        exe_d.wdata     = result;
        exe_d.excp_ri   = dec_i.excp_ri;
        exe_d.excp_ov   = dec_i.valid && ovf;
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            exe_q <= '0;
        end else begin
            exe_q <= exe_d;
        end
    end

    assign exe_o = exe_q;

    a_ov_only_add_sub: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (exe_q.valid && exe_q.excp_ov) |->
        ($past(dec_i.alu_op) == mips_pkg::ALU_ADD || $past(dec_i.alu_op) == mips_pkg::ALU_SUB));

endmodule

//--- writeback_regfile.sv
module writeback_regfile (
    input  logic                              clk_i,
    input  logic                              arst_n_i,
    input  mips_pkg::exe_t                    exe_i,
    input  logic [mips_pkg::REG_ADDR_W-1:0]   rd_addr_a_i,
    input  logic [mips_pkg::REG_ADDR_W-1:0]   rd_addr_b_i,
    output logic [mips_pkg::XLEN-1:0]         rd_data_a_o,
    output logic [mips_pkg::XLEN-1:0]         rd_data_b_o,
    output mips_pkg::wb_t                     wb_o
);

    logic [mips_pkg::XLEN-1:0] regs [mips_pkg::NUM_REGS];
    logic                      wr_en;
    mips_pkg::wb_t             wb_q;

    // no write on exceptions or to r0
    assign wr_en = exe_i.valid && exe_i.reg_write && !exe_i.excp_ri &&
                   !exe_i.excp_ov && (exe_i.waddr != '0);

    //--------------------------------------------------------------------------
    // register file
    //--------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < mips_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[exe_i.waddr] <= exe_i.wdata;
        end
    end

    assign rd_data_a_o = (rd_addr_a_i == '0) ? '0 : regs[rd_addr_a_i];
    assign rd_data_b_o = (rd_addr_b_i == '0) ? '0 : regs[rd_addr_b_i];

    //--------------------------------------------------------------------------
    // writeback report
    //--------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_q <= '0;
        end else begin
            wb_q.valid     <= exe_i.valid;
            wb_q.reg_write <= exe_i.reg_write;
            wb_q.waddr     <= exe_i.waddr;
            wb_q.wdata     <= exe_i.wdata;
            wb_q.excp_ri   <= exe_i.excp_ri;
            wb_q.excp_ov   <= exe_i.excp_ov;
        end
    end

    assign wb_o = wb_q;

    a_r0_stays_zero: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        regs[0] == '0);

endmodule

//--- mips_core_top.sv
module mips_core_top (
    input  logic                      clk_i,
    input  logic                      arst_n_i,
    input  logic                      inst_valid_i,
    input  logic [mips_pkg::XLEN-1:0] inst_i,
    output mips_pkg::wb_t             wb_o
);

    mips_pkg::dec_t                    dec_q;
    mips_pkg::exe_t                    exe_q;
    logic [mips_pkg::REG_ADDR_W-1:0]   rd_addr_a;
    logic [mips_pkg::REG_ADDR_W-1:0]   rd_addr_b;
    logic [mips_pkg::XLEN-1:0]         rd_data_a;
    logic [mips_pkg::XLEN-1:0]         rd_data_b;

    inst_decode u_decode (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .dec_o        (dec_q)
    );

    alu_execute u_execute (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .dec_i       (dec_q),
        .rd_addr_a_o (rd_addr_a),
        .rd_addr_b_o (rd_addr_b),
        .rd_data_a_i (rd_data_a),
        .rd_data_b_i (rd_data_b),
        .exe_o       (exe_q)
    );

    writeback_regfile u_writeback (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .exe_i       (exe_q),
        .rd_addr_a_i (rd_addr_a),
        .rd_addr_b_i (rd_addr_b),
        .rd_data_a_o (rd_data_a),
        .rd_data_b_o (rd_data_b),
        .wb_o        (wb_o)
    );

endmodule

//--- tb_core.sv
module tb_core;
    timeunit 1ns;
    timeprecision 1ps;

    logic          clk_i;
    logic          arst_n_i;
    logic          inst_valid_i;
    logic [31:0]   inst_i;
    mips_pkg::wb_t wb_o;

    // architectural registers as the instructions define them
    logic [31:0]   ref_regs [32];
    mips_pkg::wb_t exp_q [$];
    mips_pkg::wb_t exp_wb;
    int            mismatch_cnt;
    int            other_cnt;

    mips_core_top DUT (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .wb_o         (wb_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    //--------------------------------------------------------------------------
    // encoding and reference model
    //--------------------------------------------------------------------------
    function automatic logic [31:0] rop(input logic [5:0] fn, input logic [4:0] rd,
                                        input logic [4:0] rs, input logic [4:0] rt,
                                        input logic [4:0] sh);
        return {6'd0, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] iop(input logic [5:0] op, input logic [4:0] rt,
                                        input logic [4:0] rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // overflow seen as a carry into the sign of a 33-bit result
    function automatic logic signed_ovf(input logic [31:0] a, input logic [31:0] b,
                                        input logic sub);
        logic [32:0] s;
        s = sub ? ({a[31], a} - {b[31], b}) : ({a[31], a} + {b[31], b});
        return s[32] != s[31];
    endfunction

    task automatic model_issue(input logic [31:0] w);
        logic [4:0]    rs;
        logic [4:0]    rt;
        logic [4:0]    amt;
        logic [31:0]   a;
        logic [31:0]   b;
        logic [31:0]   sx;
        logic [31:0]   zx;
        logic          fixed_sh;
        mips_pkg::wb_t e;
        rs = w[25:21];
        rt = w[20:16];
        a = ref_regs[rs];
        b = ref_regs[rt];
        sx = {{16{w[15]}}, w[15:0]};
        zx = {16'd0, w[15:0]};
        fixed_sh = (w[5:0] == mips_pkg::FN_SLL) || (w[5:0] == mips_pkg::FN_SRL) ||
                   (w[5:0] == mips_pkg::FN_SRA);
        amt = fixed_sh ? w[10:6] : a[4:0];
        e = '0;
        e.valid = 1'b1;
        e.reg_write = 1'b1;
        e.waddr = rt;
        if (w[31:26] == mips_pkg::OP_SPECIAL) begin
            // fixed shifts need rs clear, everything else needs shamt clear
            e.reg_write = fixed_sh ? (rs == 5'd0) : (w[10:6] == 5'd0);
            e.waddr = w[15:11];
            case (w[5:0])
                mips_pkg::FN_SLL, mips_pkg::FN_SLLV: e.wdata = b << amt;
                mips_pkg::FN_SRL, mips_pkg::FN_SRLV: e.wdata = b >> amt;
                mips_pkg::FN_SRA, mips_pkg::FN_SRAV: e.wdata = $signed(b) >>> amt;
                mips_pkg::FN_ADD, mips_pkg::FN_ADDU: e.wdata = a + b;
                mips_pkg::FN_SUB, mips_pkg::FN_SUBU: e.wdata = a - b;
                mips_pkg::FN_AND:  e.wdata = a & b;
                mips_pkg::FN_OR:   e.wdata = a | b;
                mips_pkg::FN_XOR:  e.wdata = a ^ b;
                mips_pkg::FN_NOR:  e.wdata = ~(a | b);
                mips_pkg::FN_SLT:  e.wdata = {31'd0, $signed(a) < $signed(b)};
                mips_pkg::FN_SLTU: e.wdata = {31'd0, a < b};
                default:           e.reg_write = 1'b0;
            endcase
            e.excp_ov = (w[5:0] == mips_pkg::FN_ADD && signed_ovf(a, b, 1'b0)) ||
                        (w[5:0] == mips_pkg::FN_SUB && signed_ovf(a, b, 1'b1));
        end else begin
            case (w[31:26])
                mips_pkg::OP_ADDI, mips_pkg::OP_ADDIU: e.wdata = a + sx;
                mips_pkg::OP_SLTI:  e.wdata = {31'd0, $signed(a) < $signed(sx)};
                mips_pkg::OP_SLTIU: e.wdata = {31'd0, a < sx};
                mips_pkg::OP_ANDI:  e.wdata = a & zx;
                mips_pkg::OP_ORI:   e.wdata = a | zx;
                mips_pkg::OP_XORI:  e.wdata = a ^ zx;
                mips_pkg::OP_LUI: begin
                    e.reg_write = (rs == 5'd0);
                    e.wdata = {w[15:0], 16'd0};
                end
                default: e.reg_write = 1'b0;
            endcase
            e.excp_ov = (w[31:26] == mips_pkg::OP_ADDI) && signed_ovf(a, sx, 1'b0);
        end
        // reserved words report rt with a zero result
        if (!e.reg_write) begin
            e.excp_ri = 1'b1;
            e.waddr = rt;
            e.wdata = '0;
            e.excp_ov = 1'b0;
        end else if (!e.excp_ov && e.waddr != 5'd0) begin
            ref_regs[e.waddr] = e.wdata;
        end
        exp_q.push_back(e);
    endtask

    //--------------------------------------------------------------------------
    // driving and checking
    //--------------------------------------------------------------------------
    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s got 0x%08h expected 0x%08h", name, got, exp);
            mismatch_cnt++;
        end
    endtask

    always @(negedge clk_i) begin
        if (arst_n_i && wb_o.valid) begin
            if (exp_q.size() == 0) begin
                $display("writeback report arrived with no instruction outstanding");
                other_cnt++;
            end else begin
                exp_wb = exp_q.pop_front();
                check_val("wb_o.reg_write", wb_o.reg_write, exp_wb.reg_write);
                check_val("wb_o.waddr", wb_o.waddr, exp_wb.waddr);
                check_val("wb_o.wdata", wb_o.wdata, exp_wb.wdata);
                check_val("wb_o.excp_ri", wb_o.excp_ri, exp_wb.excp_ri);
                check_val("wb_o.excp_ov", wb_o.excp_ov, exp_wb.excp_ov);
            end
        end
    end

    task automatic send(input logic [31:0] w);
        @(posedge clk_i);
        #2;
        inst_valid_i = 1'b1;
        inst_i = w;
        model_issue(w);
    endtask

    task automatic set_reg(input logic [4:0] r, input logic [31:0] v);
        send(iop(mips_pkg::OP_LUI, r, 5'd0, v[31:16]));
        send(iop(mips_pkg::OP_ORI, r, r, v[15:0]));
    endtask

    // stop issuing and wait for every report to come back
    task automatic drain();
        int n;
        @(posedge clk_i);
        #2;
        inst_valid_i = 1'b0;
        inst_i = $urandom();
        for (n = 0; n < 20 && exp_q.size() != 0; n++) begin
            @(posedge clk_i);
        end
        if (exp_q.size() != 0) begin
            $display("timed out with %0d reports still outstanding", exp_q.size());
            other_cnt++;
            exp_q.delete();
        end
    endtask

    //--------------------------------------------------------------------------
    // directed tests
    //--------------------------------------------------------------------------
    task automatic reset_and_latency();
        int n;
        for (n = 0; n < 15; n++) begin
            @(posedge clk_i);
            #2;
            if (n == 4) begin
                arst_n_i = 1'b1;
            end
            if (wb_o.valid !== 1'b0) begin
                $display("wb_o.valid went high with nothing issued, cycle %0d", n);
                other_cnt++;
            end
        end
        send(iop(mips_pkg::OP_ORI, 5'd1, 5'd0, 16'h1234));
        n = 0;
        while (wb_o.valid !== 1'b1 && n < 10) begin
            @(posedge clk_i);
            #2;
            n++;
            if (n == 1) begin
                inst_valid_i = 1'b0;
            end
        end
        if (n != 3) begin
            $display("report came %0d edges after the sampling edge instead of 3", n);
            other_cnt++;
        end
        drain();
    endtask

    task automatic logic_ops();
        int i;
        for (i = 1; i <= 4; i++) begin
            set_reg(5'(i), $urandom());
        end
        send(rop(mips_pkg::FN_AND, 5'd5, 5'd1, 5'd2, 5'd0));
        send(rop(mips_pkg::FN_OR, 5'd6, 5'd1, 5'd3, 5'd0));
        send(rop(mips_pkg::FN_XOR, 5'd7, 5'd2, 5'd4, 5'd0));
        send(rop(mips_pkg::FN_NOR, 5'd8, 5'd3, 5'd4, 5'd0));
        // bit 15 set so a sign extension would show
        send(iop(mips_pkg::OP_ANDI, 5'd9, 5'd1, 16'h8000 | 16'($urandom())));
        send(iop(mips_pkg::OP_ORI, 5'd10, 5'd2, 16'h8000 | 16'($urandom())));
        send(iop(mips_pkg::OP_XORI, 5'd11, 5'd3, 16'h8001));
        drain();
    endtask

    task automatic shift_ops();
        int          i;
        logic [4:0]  sh;
        set_reg(5'd12, 32'h8000_0000 | $urandom());
        // shift count register above 31
        set_reg(5'd13, 32'h0000_7f00 | ($urandom() & 32'h1f));
        for (i = 0; i < 3; i++) begin
            sh = 5'($urandom());
            send(rop(mips_pkg::FN_SLL, 5'd14, 5'd0, 5'd12, sh));
            send(rop(mips_pkg::FN_SRL, 5'd15, 5'd0, 5'd12, sh));
            send(rop(mips_pkg::FN_SRA, 5'd16, 5'd0, 5'd12, sh));
        end
        send(rop(mips_pkg::FN_SLLV, 5'd17, 5'd13, 5'd12, 5'd0));
        send(rop(mips_pkg::FN_SRLV, 5'd18, 5'd13, 5'd12, 5'd0));
        send(rop(mips_pkg::FN_SRAV, 5'd19, 5'd13, 5'd12, 5'd0));
        drain();
    endtask

    task automatic arith_ops();
        set_reg(5'd1, 32'h7fff_ffff);
        set_reg(5'd2, 32'h8000_0000);
        send(iop(mips_pkg::OP_ADDIU, 5'd3, 5'd0, 16'hffff));
        send(rop(mips_pkg::FN_ADDU, 5'd4, 5'd2, 5'd2, 5'd0));
        send(iop(mips_pkg::OP_ADDIU, 5'd5, 5'd3, 16'h0001));
        send(rop(mips_pkg::FN_SLT, 5'd6, 5'd2, 5'd1, 5'd0));
        send(rop(mips_pkg::FN_SLTU, 5'd7, 5'd2, 5'd1, 5'd0));
        send(iop(mips_pkg::OP_SLTI, 5'd8, 5'd3, 16'h0001));
        send(iop(mips_pkg::OP_SLTIU, 5'd9, 5'd3, 16'h0001));
        // in range, these write normally
        send(rop(mips_pkg::FN_ADD, 5'd12, 5'd1, 5'd2, 5'd0));
        send(rop(mips_pkg::FN_SUB, 5'd13, 5'd2, 5'd3, 5'd0));
        send(iop(mips_pkg::OP_ADDI, 5'd14, 5'd3, 16'h0001));
        send(iop(mips_pkg::OP_ORI, 5'd10, 5'd0, 16'h1234));
        // each of these overflows, r10 keeps 0x1234
        send(rop(mips_pkg::FN_ADD, 5'd10, 5'd1, 5'd1, 5'd0));
        send(rop(mips_pkg::FN_SUB, 5'd10, 5'd2, 5'd1, 5'd0));
        send(iop(mips_pkg::OP_ADDI, 5'd10, 5'd1, 16'h0001));
        send(rop(mips_pkg::FN_OR, 5'd11, 5'd10, 5'd0, 5'd0));
        drain();
    endtask

    task automatic reserved_and_r0();
        send(iop(mips_pkg::OP_ORI, 5'd20, 5'd0, 16'h5a5a));
        send(iop(6'b100011, 5'd20, 5'd1, 16'h0004));
        send(rop(mips_pkg::FN_ADD, 5'd20, 5'd1, 5'd2, 5'd3));
        send(rop(6'b011000, 5'd0, 5'd1, 5'd20, 5'd0));
        send(iop(mips_pkg::OP_LUI, 5'd20, 5'd1, 16'hffff));
        send(rop(mips_pkg::FN_OR, 5'd21, 5'd20, 5'd0, 5'd0));
        send(iop(mips_pkg::OP_ORI, 5'd0, 5'd0, 16'hffff));
        send(rop(mips_pkg::FN_OR, 5'd22, 5'd0, 5'd0, 5'd0));
        send(iop(mips_pkg::OP_ADDIU, 5'd23, 5'd0, 16'h0005));
        drain();
    endtask

    task automatic forward_chain();
        int          i;
        logic [4:0]  src;
        logic [4:0]  dst;
        logic [4:0]  oth;
        logic [31:0] w;
        for (i = 1; i < 8; i++) begin
            set_reg(5'(i), $urandom());
        end
        dst = 5'd1;
        // every instruction reads the previous destination
        for (i = 0; i < 20; i++) begin
            src = dst;
            dst = 5'($urandom_range(1, 7));
            oth = 5'($urandom_range(0, 7));
            case ($urandom_range(0, 7))
                0: w = rop(mips_pkg::FN_ADDU, dst, src, oth, 5'd0);
                1: w = rop(mips_pkg::FN_SUBU, dst, oth, src, 5'd0);
                2: w = rop(mips_pkg::FN_XOR, dst, src, oth, 5'd0);
                3: w = rop(mips_pkg::FN_SLT, dst, src, oth, 5'd0);
                4: w = rop(mips_pkg::FN_SRAV, dst, oth, src, 5'd0);
                5: w = rop(mips_pkg::FN_SLL, dst, 5'd0, src, 5'($urandom()));
                6: w = iop(mips_pkg::OP_ADDIU, dst, src, 16'($urandom()));
                default: w = iop(mips_pkg::OP_ORI, dst, src, 16'($urandom()));
            endcase
            send(w);
        end
        drain();
    endtask

    initial begin
        int r;
        void'($urandom(17));
        arst_n_i = 1'b0;
        inst_valid_i = 1'b0;
        inst_i = '0;
        mismatch_cnt = 0;
        other_cnt = 0;
        for (r = 0; r < 32; r++) begin
            ref_regs[r] = '0;
        end
        reset_and_latency();
        logic_ops();
        shift_ops();
        arith_ops();
        reserved_and_r0();
        forward_chain();
        $display("error counts: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
        if (mismatch_cnt == 0 && other_cnt == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- tb.f
mips_pkg.sv
inst_decode.sv
alu_execute.sv
writeback_regfile.sv
mips_core_top.sv
tb_core.sv

//--- run.sh
#!/bin/sh
# build and run the core testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_core -o sim_core &&
./obj_dir/sim_core > sim.log 2>&1 || echo "build or simulation did not complete" >> sim.log
cat sim.log
grep -q "Simulation finished: FAIL" sim.log && exit 1
grep -q "Simulation finished: PASS" sim.log || exit 1
exit 0
